//--- Bender.yml
package:
  name: rv_decode

export_include_dirs:
  - .

sources:
  - rv_decode_pkg.sv
  - rv_inst_decode.sv
  - rv_operand_fwd.sv
  - rv_operand_sel.sv
  - rv_branch_resolve.sv
  - rv_decode_top.sv
  - target: test
    files:
      - tb_rv_decode_sva.sv
      - tb_rv_decode.sv

//--- rv_branch_resolve.sv
// branch redirect only on misprediction; jalr has no target prediction and always redirects
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_branch_resolve (
  input  rv_decode_pkg::dec_t      dec_i,
  input  logic [`RV_XLEN-1:0]      pc_i,
  input  logic [`RV_XLEN-1:0]      op1_i,
  input  logic [`RV_XLEN-1:0]      op2_i,
  input  logic                     pht_taken_i,
  output logic                     redirect_o,
  output logic [`RV_XLEN-1:0]      redirect_pc_o,
  output rv_decode_pkg::pht_upd_t  pht_upd_o
);
  import rv_decode_pkg::*;

  logic                is_br;
  logic                is_jalr;
  logic                outcome;
  logic                br_miss;
  logic [`RV_XLEN-1:0] jalr_tgt;

  assign is_br   = (dec_i.cls == CLS_BRANCH);
  assign is_jalr = (dec_i.cls == CLS_JALR);

  always_comb begin
    case (dec_i.uop)
      UOP_BEQ:  outcome = (op1_i == op2_i);
      UOP_BNE:  outcome = (op1_i != op2_i);
      UOP_BLT:  outcome = ($signed(op1_i) < $signed(op2_i));
      UOP_BGE:  outcome = ($signed(op1_i) >= $signed(op2_i));
      UOP_BLTU: outcome = (op1_i < op2_i);
      UOP_BGEU: outcome = (op1_i >= op2_i);
      default:  outcome = 1'b0;
    endcase
  end

  assign br_miss  = is_br && (outcome != pht_taken_i);
  assign jalr_tgt = op1_i + dec_i.imm_i;

  always_comb begin
    redirect_o    = br_miss || is_jalr;
    redirect_pc_o = '0;
    if (br_miss) begin
      // predicted taken means fall through was skipped
      redirect_pc_o = pht_taken_i ? pc_i + `RV_XLEN'd4 : pc_i + dec_i.imm_b;
    end else if (is_jalr) begin
      redirect_pc_o = {jalr_tgt[`RV_XLEN-1:1], 1'b0};
    end
  end

  always_comb begin
    pht_upd_o.ena   = is_br;
    pht_upd_o.idx   = is_br ? pc_i[`RV_PHT_IDX_W+1:2] : '0;
    pht_upd_o.taken = is_br && outcome;
  end

endmodule

//--- rv_decode_params.svh
// rv64 only; pht index width is tied to pc bits 5..2 and opcodes cover the base integer set
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

`define RV_XLEN       64
`define RV_INST_W     32
`define RV_REG_AW     5
`define RV_PHT_IDX_W  4

// major opcodes, full seven bits
`define RV_OPC_LOAD       7'b0000011
`define RV_OPC_STORE      7'b0100011
`define RV_OPC_BRANCH     7'b1100011
`define RV_OPC_JALR       7'b1100111
`define RV_OPC_JAL        7'b1101111
`define RV_OPC_OP_IMM     7'b0010011
`define RV_OPC_OP_IMM_32  7'b0011011
`define RV_OPC_OP         7'b0110011
`define RV_OPC_OP_32      7'b0111011
`define RV_OPC_LUI        7'b0110111
`define RV_OPC_AUIPC      7'b0010111

`endif

//--- rv_decode_pkg.sv
// types assume rv64 with a 32-bit word; imm_u stays unshifted and execute applies the shift
`include "rv_decode_params.svh"

package rv_decode_pkg;

  // instruction word views, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits stay where the encoding scatters them
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
  } inst_u;

  typedef enum logic [3:0] {
    CLS_NONE, CLS_OP, CLS_OP_32, CLS_OP_IMM, CLS_OP_IMM_32, CLS_LUI,
    CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH, CLS_LOAD, CLS_STORE
  } inst_class_e;

  typedef enum logic [5:0] {
    UOP_NONE,
    UOP_ADD, UOP_SUB, UOP_SLL, UOP_SLT, UOP_SLTU,
    UOP_XOR, UOP_SRL, UOP_SRA, UOP_OR, UOP_AND,
    UOP_ADDW, UOP_SUBW, UOP_SLLW, UOP_SRLW, UOP_SRAW,
    UOP_ADDI, UOP_SLTI, UOP_SLTIU, UOP_XORI, UOP_ORI,
    UOP_ANDI, UOP_SLLI, UOP_SRLI, UOP_SRAI,
    UOP_ADDIW, UOP_SLLIW, UOP_SRLIW, UOP_SRAIW,
    UOP_LUI, UOP_AUIPC, UOP_JAL, UOP_JALR,
    UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
    UOP_LB, UOP_LH, UOP_LW, UOP_LD, UOP_LBU, UOP_LHU, UOP_LWU,
    UOP_SB, UOP_SH, UOP_SW, UOP_SD
  } uop_e;

  typedef struct packed {
    inst_class_e              cls;
    uop_e                     uop;
    logic [`RV_REG_AW-1:0]    rs1;
    logic                     rs1_re;
    logic [`RV_REG_AW-1:0]    rs2;
    logic                     rs2_re;
    logic [`RV_REG_AW-1:0]    rd;
    logic                     rd_we;
    logic [`RV_XLEN-1:0]      imm_i;
    logic [`RV_XLEN-1:0]      imm_s;
    logic [`RV_XLEN-1:0]      imm_b;
    logic [`RV_XLEN-1:0]      imm_u;
    logic [2:0]               funct3;
  } dec_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   data;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic                  rd_ena;
  } bypass_t;

  typedef struct packed {
    logic                     ena;
    logic [`RV_PHT_IDX_W-1:0] idx;
    logic                     taken;
  } pht_upd_t;

  typedef struct packed {
    logic                  valid;
    inst_class_e           cls;
    uop_e                  uop;
    logic [`RV_XLEN-1:0]   op1;
    logic [`RV_XLEN-1:0]   op2;
    logic                  rd_we;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_INST_W-1:0] inst;
    logic [`RV_XLEN-1:0]   mem_addr;
    logic [2:0]            mem_sel;
  } id_ex_t;

endpackage

//--- rv_decode_top.sv
// single id/ex register with no stall input; it captures every cycle and id_valid_i is the only qualifier
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_decode_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     id_valid_i,
  input  logic [`RV_INST_W-1:0]    inst_i,
  input  logic [`RV_XLEN-1:0]      pc_i,
  input  logic [`RV_XLEN-1:0]      rf_rdata1_i,
  input  logic [`RV_XLEN-1:0]      rf_rdata2_i,
  output logic [`RV_REG_AW-1:0]    rf_raddr1_o,
  output logic [`RV_REG_AW-1:0]    rf_raddr2_o,
  output logic                     rf_re1_o,
  output logic                     rf_re2_o,
  input  rv_decode_pkg::bypass_t   byp_alu1_i,
  input  rv_decode_pkg::bypass_t   byp_alu2_i,
  input  rv_decode_pkg::bypass_t   byp_mem_i,
  input  logic                     pht_taken_i,
  output logic                     redirect_o,
  output logic [`RV_XLEN-1:0]      redirect_pc_o,
  output rv_decode_pkg::pht_upd_t  pht_upd_o,
  output rv_decode_pkg::id_ex_t    ex_o
);
  import rv_decode_pkg::*;

  inst_u               inst_w;
  dec_t                dec;
  logic [`RV_XLEN-1:0] rs1_fwd;
  logic [`RV_XLEN-1:0] rs2_fwd;
  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] op2;
  logic [`RV_XLEN-1:0] mem_addr;
  id_ex_t              ex_d;

  assign inst_w = inst_i;

  rv_inst_decode u_dec (
    .inst_i  (inst_w),
    .valid_i (id_valid_i),
    .dec_o   (dec)
  );

  // decode already zeroes unread addresses
  assign rf_raddr1_o = dec.rs1;
  assign rf_raddr2_o = dec.rs2;
  assign rf_re1_o    = dec.rs1_re;
  assign rf_re2_o    = dec.rs2_re;

  rv_operand_fwd u_fwd_rs1 (
    .addr_i    (dec.rs1),
    .rd_en_i   (dec.rs1_re),
    .rf_data_i (rf_rdata1_i),
    .alu1_i    (byp_alu1_i),
    .alu2_i    (byp_alu2_i),
    .mem_i     (byp_mem_i),
    .data_o    (rs1_fwd)
  );

  rv_operand_fwd u_fwd_rs2 (
    .addr_i    (dec.rs2),
    .rd_en_i   (dec.rs2_re),
    .rf_data_i (rf_rdata2_i),
    .alu1_i    (byp_alu1_i),
    .alu2_i    (byp_alu2_i),
    .mem_i     (byp_mem_i),
    .data_o    (rs2_fwd)
  );

  rv_operand_sel u_sel (
    .dec_i      (dec),
    .pc_i       (pc_i),
    .rs1_data_i (rs1_fwd),
    .rs2_data_i (rs2_fwd),
    .op1_o      (op1),
    .op2_o      (op2),
    .mem_addr_o (mem_addr)
  );

  rv_branch_resolve u_br (
    .dec_i         (dec),
    .pc_i          (pc_i),
    .op1_i         (op1),
    .op2_i         (op2),
    .pht_taken_i   (pht_taken_i),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o),
    .pht_upd_o     (pht_upd_o)
  );

  always_comb begin
    ex_d.valid    = id_valid_i;
    ex_d.cls      = dec.cls;
    ex_d.uop      = dec.uop;
    ex_d.op1      = op1;
    ex_d.op2      = op2;
    ex_d.rd_we    = dec.rd_we;
    ex_d.rd_addr  = dec.rd;
    ex_d.pc       = pc_i;
    ex_d.inst     = inst_w;
    ex_d.mem_addr = mem_addr;
    ex_d.mem_sel  = dec.funct3;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_o <= '0;
    end else begin
      ex_o <= ex_d;
    end
  end

endmodule

//--- rv_inst_decode.sv
// rv64i base set only; m extension, csr and system words decode as illegal with no reads or writes
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_inst_decode (
  input  rv_decode_pkg::inst_u inst_i,
  input  logic                 valid_i,
  output rv_decode_pkg::dec_t  dec_o
);
  import rv_decode_pkg::*;

  inst_class_e cls_raw;
  uop_e        uop_raw;
  logic [2:0]  f3;
  logic        legal;

  assign f3 = inst_i.r.funct3;

  always_comb begin
    case (inst_i.r.opcode)
      `RV_OPC_OP:        cls_raw = CLS_OP;
      `RV_OPC_OP_32:     cls_raw = CLS_OP_32;
      `RV_OPC_OP_IMM:    cls_raw = CLS_OP_IMM;
      `RV_OPC_OP_IMM_32: cls_raw = CLS_OP_IMM_32;
      `RV_OPC_LUI:       cls_raw = CLS_LUI;
      `RV_OPC_AUIPC:     cls_raw = CLS_AUIPC;
      `RV_OPC_JAL:       cls_raw = CLS_JAL;
      `RV_OPC_JALR:      cls_raw = CLS_JALR;
      `RV_OPC_BRANCH:    cls_raw = CLS_BRANCH;
      `RV_OPC_LOAD:      cls_raw = CLS_LOAD;
      `RV_OPC_STORE:     cls_raw = CLS_STORE;
      default:           cls_raw = CLS_NONE;
    endcase
  end

  always_comb begin
    uop_raw = UOP_NONE;
    case (cls_raw)
      CLS_OP: begin
        case (f3)
          3'd0:    uop_raw = inst_i.r.funct7[5] ? UOP_SUB : UOP_ADD;
          3'd1:    uop_raw = UOP_SLL;
          3'd2:    uop_raw = UOP_SLT;
          3'd3:    uop_raw = UOP_SLTU;
          3'd4:    uop_raw = UOP_XOR;
          3'd5:    uop_raw = inst_i.r.funct7[5] ? UOP_SRA : UOP_SRL;
          3'd6:    uop_raw = UOP_OR;
          default: uop_raw = UOP_AND;
        endcase
      end
      CLS_OP_32: begin
        case (f3)
          3'd0:    uop_raw = inst_i.r.funct7[5] ? UOP_SUBW : UOP_ADDW;
          3'd1:    uop_raw = UOP_SLLW;
          3'd5:    uop_raw = inst_i.r.funct7[5] ? UOP_SRAW : UOP_SRLW;
          default: uop_raw = UOP_NONE;
        endcase
      end
      CLS_OP_IMM: begin
        case (f3)
          3'd0:    uop_raw = UOP_ADDI;
          3'd1:    uop_raw = UOP_SLLI;
          3'd2:    uop_raw = UOP_SLTI;
          3'd3:    uop_raw = UOP_SLTIU;
          3'd4:    uop_raw = UOP_XORI;
          3'd5:    uop_raw = inst_i.i.imm[10] ? UOP_SRAI : UOP_SRLI;
          3'd6:    uop_raw = UOP_ORI;
          default: uop_raw = UOP_ANDI;
        endcase
      end
      CLS_OP_IMM_32: begin
        case (f3)
          3'd0:    uop_raw = UOP_ADDIW;
          3'd1:    uop_raw = UOP_SLLIW;
          3'd5:    uop_raw = inst_i.i.imm[10] ? UOP_SRAIW : UOP_SRLIW;
          default: uop_raw = UOP_NONE;
        endcase
      end
      CLS_LOAD: begin
        case (f3)
          3'd0:    uop_raw = UOP_LB;
          3'd1:    uop_raw = UOP_LH;
          3'd2:    uop_raw = UOP_LW;
          3'd3:    uop_raw = UOP_LD;
          3'd4:    uop_raw = UOP_LBU;
          3'd5:    uop_raw = UOP_LHU;
          3'd6:    uop_raw = UOP_LWU;
          default: uop_raw = UOP_NONE;
        endcase
      end
      CLS_STORE: begin
        case (f3)
          3'd0:    uop_raw = UOP_SB;
          3'd1:    uop_raw = UOP_SH;
          3'd2:    uop_raw = UOP_SW;
          3'd3:    uop_raw = UOP_SD;
          default: uop_raw = UOP_NONE;
        endcase
      end
      CLS_BRANCH: begin
        case (f3)
          3'd0:    uop_raw = UOP_BEQ;
          3'd1:    uop_raw = UOP_BNE;
          3'd4:    uop_raw = UOP_BLT;
          3'd5:    uop_raw = UOP_BGE;
          3'd6:    uop_raw = UOP_BLTU;
          3'd7:    uop_raw = UOP_BGEU;
          default: uop_raw = UOP_NONE;
        endcase
      end
      CLS_JALR:  uop_raw = (f3 == 3'd0) ? UOP_JALR : UOP_NONE;
      CLS_JAL:   uop_raw = UOP_JAL;
      CLS_LUI:   uop_raw = UOP_LUI;
      CLS_AUIPC: uop_raw = UOP_AUIPC;
      default:   uop_raw = UOP_NONE;
    endcase
    // m extension sets funct7 bit 0
    if ((cls_raw == CLS_OP || cls_raw == CLS_OP_32) && inst_i.r.funct7[0]) begin
      uop_raw = UOP_NONE;
    end
  end

  assign legal = valid_i && (uop_raw != UOP_NONE);

  always_comb begin
    dec_o.cls    = legal ? cls_raw : CLS_NONE;
    dec_o.uop    = legal ? uop_raw : UOP_NONE;
    dec_o.rs1_re = legal && !(cls_raw inside {CLS_LUI, CLS_AUIPC, CLS_JAL});
    dec_o.rs2_re = legal && (cls_raw inside {CLS_OP, CLS_OP_32, CLS_BRANCH, CLS_STORE});
    dec_o.rd_we  = legal && !(cls_raw inside {CLS_BRANCH, CLS_STORE});
    dec_o.rs1    = dec_o.rs1_re ? inst_i.r.rs1 : '0;
    dec_o.rs2    = dec_o.rs2_re ? inst_i.r.rs2 : '0;
    dec_o.rd     = dec_o.rd_we ? inst_i.r.rd : '0;
    dec_o.imm_i  = {{(`RV_XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
    dec_o.imm_s  = {{(`RV_XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    // branch offset reassembled, bit 0 always zero
    dec_o.imm_b  = {{(`RV_XLEN-13){inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                    inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
    dec_o.imm_u  = {{(`RV_XLEN-20){inst_i.u.imm[19]}}, inst_i.u.imm};
    dec_o.funct3 = f3;
  end

endmodule

//--- rv_operand_fwd.sv
// one source operand; youngest bypass by pc wins, ties go alu1 then alu2 then mem
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_operand_fwd (
  input  logic [`RV_REG_AW-1:0]  addr_i,
  input  logic                   rd_en_i,
  input  logic [`RV_XLEN-1:0]    rf_data_i,
  input  rv_decode_pkg::bypass_t alu1_i,
  input  rv_decode_pkg::bypass_t alu2_i,
  input  rv_decode_pkg::bypass_t mem_i,
  output logic [`RV_XLEN-1:0]    data_o
);
  import rv_decode_pkg::*;

  logic                hit_alu1;
  logic                hit_alu2;
  logic                hit_mem;
  logic                found;
  logic [`RV_XLEN-1:0] best_pc;
  logic [`RV_XLEN-1:0] best_data;

  // x0 never forwards
  function automatic logic src_hit(input bypass_t byp, input logic [`RV_REG_AW-1:0] addr);
    return byp.rd_ena && (byp.rd_addr == addr) && (addr != '0);
  endfunction

  assign hit_alu1 = src_hit(alu1_i, addr_i);
  assign hit_alu2 = src_hit(alu2_i, addr_i);
  assign hit_mem  = src_hit(mem_i, addr_i);

  always_comb begin
    found     = hit_alu1;
    best_pc   = alu1_i.pc;
    best_data = alu1_i.data;
    // strict compare keeps the earlier source on equal pc
    if (hit_alu2 && (!found || alu2_i.pc > best_pc)) begin
      found     = 1'b1;
      best_pc   = alu2_i.pc;
      best_data = alu2_i.data;
    end
    if (hit_mem && (!found || mem_i.pc > best_pc)) begin
      found     = 1'b1;
      best_pc   = mem_i.pc;
      best_data = mem_i.data;
    end
    if (!rd_en_i) begin
      data_o = '0;
    end else if (found) begin
      data_o = best_data;
    end else begin
      data_o = rf_data_i;
    end
  end

endmodule

//--- rv_operand_sel.sv
// operands follow the decoded class; lui and auipc carry imm_u unshifted in op2
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_operand_sel (
  input  rv_decode_pkg::dec_t  dec_i,
  input  logic [`RV_XLEN-1:0]  pc_i,
  input  logic [`RV_XLEN-1:0]  rs1_data_i,
  input  logic [`RV_XLEN-1:0]  rs2_data_i,
  output logic [`RV_XLEN-1:0]  op1_o,
  output logic [`RV_XLEN-1:0]  op2_o,
  output logic [`RV_XLEN-1:0]  mem_addr_o
);
  import rv_decode_pkg::*;

  always_comb begin
    if (dec_i.rs1_re) begin
      op1_o = rs1_data_i;
    end else if (dec_i.cls == CLS_AUIPC || dec_i.cls == CLS_JAL) begin
      op1_o = pc_i;
    end else begin
      op1_o = '0;
    end
  end

  always_comb begin
    case (dec_i.cls)
      CLS_OP, CLS_OP_32, CLS_BRANCH, CLS_STORE: begin
        op2_o = rs2_data_i;
      end
      CLS_OP_IMM, CLS_OP_IMM_32, CLS_LOAD: begin
        op2_o = dec_i.imm_i;
      end
      CLS_LUI, CLS_AUIPC: begin
        op2_o = dec_i.imm_u;
      end
      // link value is formed in execute from the pc
      CLS_JAL, CLS_JALR: begin
        op2_o = pc_i;
      end
      default: begin
        op2_o = '0;
      end
    endcase
  end

  always_comb begin
    case (dec_i.cls)
      CLS_LOAD:  mem_addr_o = op1_o + dec_i.imm_i;
      CLS_STORE: mem_addr_o = op1_o + dec_i.imm_s;
      default:   mem_addr_o = '0;
    endcase
  end

endmodule

//--- sources.f
+incdir+.
rv_decode_pkg.sv
rv_inst_decode.sv
rv_operand_fwd.sv
rv_operand_sel.sv
rv_branch_resolve.sv
rv_decode_top.sv
tb_rv_decode_sva.sv
tb_rv_decode.sv

//--- tb_rv_decode.sv
// random rv64i stimulus against a behavioral model; rd_addr and mem_sel are compared only where used
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module tb_rv_decode;
  import rv_decode_pkg::*;

  localparam int num_inst = 3000;
  localparam int rst_cyc  = 16;

  localparam logic [6:0] kept_opc [11] = '{`RV_OPC_LOAD, `RV_OPC_STORE, `RV_OPC_BRANCH,
    `RV_OPC_JALR, `RV_OPC_JAL, `RV_OPC_OP_IMM, `RV_OPC_OP_IMM_32, `RV_OPC_OP, `RV_OPC_OP_32,
    `RV_OPC_LUI, `RV_OPC_AUIPC};
  localparam logic [2:0] w32_f3 [3] = '{3'd0, 3'd1, 3'd5};

  // micro-op per funct3, base forms only
  localparam uop_e op_tab [8] = '{UOP_ADD, UOP_SLL, UOP_SLT, UOP_SLTU,
    UOP_XOR, UOP_SRL, UOP_OR, UOP_AND};
  localparam uop_e opi_tab [8] = '{UOP_ADDI, UOP_SLLI, UOP_SLTI, UOP_SLTIU,
    UOP_XORI, UOP_SRLI, UOP_ORI, UOP_ANDI};
  localparam uop_e opw_tab [8] = '{UOP_ADDW, UOP_SLLW, UOP_NONE, UOP_NONE,
    UOP_NONE, UOP_SRLW, UOP_NONE, UOP_NONE};
  localparam uop_e opiw_tab [8] = '{UOP_ADDIW, UOP_SLLIW, UOP_NONE, UOP_NONE,
    UOP_NONE, UOP_SRLIW, UOP_NONE, UOP_NONE};
  localparam uop_e ld_tab [8] = '{UOP_LB, UOP_LH, UOP_LW, UOP_LD,
    UOP_LBU, UOP_LHU, UOP_LWU, UOP_NONE};
  localparam uop_e st_tab [8] = '{UOP_SB, UOP_SH, UOP_SW, UOP_SD,
    UOP_NONE, UOP_NONE, UOP_NONE, UOP_NONE};
  localparam uop_e br_tab [8] = '{UOP_BEQ, UOP_BNE, UOP_NONE, UOP_NONE,
    UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU};

  typedef struct packed {
    inst_class_e         cls;
    uop_e                uop;
    logic                re1;
    logic                re2;
    logic                rd_we;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [`RV_XLEN-1:0] mem_addr;
    logic                redirect;
    logic [`RV_XLEN-1:0] redirect_pc;
    logic                pht_ena;
    logic                taken;
  } exp_t;

  logic                  clk;
  logic                  arst_n;
  logic                  id_valid;
  logic [`RV_INST_W-1:0] inst;
  logic [`RV_XLEN-1:0]   pc;
  logic [`RV_XLEN-1:0]   rf_rdata1;
  logic [`RV_XLEN-1:0]   rf_rdata2;
  logic [`RV_REG_AW-1:0] rf_raddr1;
  logic [`RV_REG_AW-1:0] rf_raddr2;
  logic                  rf_re1;
  logic                  rf_re2;
  bypass_t               byp [3];
  logic                  pht_taken;
  logic                  redirect;
  logic [`RV_XLEN-1:0]   redirect_pc;
  pht_upd_t              pht_upd;
  id_ex_t                ex;
  integer                seed;
  int                    errors;
  exp_t                  cur;
  exp_t                  prev;
  logic [`RV_INST_W-1:0] prev_inst;
  logic [`RV_XLEN-1:0]   prev_pc;
  logic                  prev_valid;

  rv_decode_top i_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .id_valid_i    (id_valid),
    .inst_i        (inst),
    .pc_i          (pc),
    .rf_rdata1_i   (rf_rdata1),
    .rf_rdata2_i   (rf_rdata2),
    .rf_raddr1_o   (rf_raddr1),
    .rf_raddr2_o   (rf_raddr2),
    .rf_re1_o      (rf_re1),
    .rf_re2_o      (rf_re2),
    .byp_alu1_i    (byp[0]),
    .byp_alu2_i    (byp[1]),
    .byp_mem_i     (byp[2]),
    .pht_taken_i   (pht_taken),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .pht_upd_o     (pht_upd),
    .ex_o          (ex)
  );

  bind rv_decode_top tb_rv_decode_sva u_sva (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .id_valid_i  (id_valid_i),
    .inst_i      (inst_i),
    .pht_taken_i (pht_taken_i),
    .redirect_i  (redirect_o),
    .pht_upd_i   (pht_upd_o),
    .ex_i        (ex_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #((num_inst + rst_cyc + 10) * 20 * 2);
    $display("timeout: the test did not reach its end in time");
    $display("Simulation FAILED");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [`RV_XLEN-1:0] got,
                                 input logic [`RV_XLEN-1:0] want);
    errors++;
    $display("mismatch %s: got %h expected %h at %0t", name, got, want, $time);
  endtask

  task automatic classify(input logic [31:0] w, output inst_class_e c, output uop_e u);
    logic [2:0] f3;
    f3 = w[14:12];
    case (w[6:0])
      `RV_OPC_OP:        c = CLS_OP;
      `RV_OPC_OP_32:     c = CLS_OP_32;
      `RV_OPC_OP_IMM:    c = CLS_OP_IMM;
      `RV_OPC_OP_IMM_32: c = CLS_OP_IMM_32;
      `RV_OPC_LUI:       c = CLS_LUI;
      `RV_OPC_AUIPC:     c = CLS_AUIPC;
      `RV_OPC_JAL:       c = CLS_JAL;
      `RV_OPC_JALR:      c = CLS_JALR;
      `RV_OPC_BRANCH:    c = CLS_BRANCH;
      `RV_OPC_LOAD:      c = CLS_LOAD;
      `RV_OPC_STORE:     c = CLS_STORE;
      default:           c = CLS_NONE;
    endcase
    case (c)
      CLS_OP:        u = op_tab[f3];
      CLS_OP_32:     u = opw_tab[f3];
      CLS_OP_IMM:    u = opi_tab[f3];
      CLS_OP_IMM_32: u = opiw_tab[f3];
      CLS_LOAD:      u = ld_tab[f3];
      CLS_STORE:     u = st_tab[f3];
      CLS_BRANCH:    u = br_tab[f3];
      CLS_JALR:      u = (f3 == 3'd0) ? UOP_JALR : UOP_NONE;
      CLS_JAL:       u = UOP_JAL;
      CLS_LUI:       u = UOP_LUI;
      CLS_AUIPC:     u = UOP_AUIPC;
      default:       u = UOP_NONE;
    endcase
    // bit 30 picks sub and arithmetic shifts
    if (w[30]) begin
      case (u)
        UOP_ADD:   u = UOP_SUB;
        UOP_SRL:   u = UOP_SRA;
        UOP_ADDW:  u = UOP_SUBW;
        UOP_SRLW:  u = UOP_SRAW;
        UOP_SRLI:  u = UOP_SRAI;
        UOP_SRLIW: u = UOP_SRAIW;
        default:   u = u;
      endcase
    end
    // m extension
    if ((c == CLS_OP || c == CLS_OP_32) && w[25]) u = UOP_NONE;
    if (u == UOP_NONE) c = CLS_NONE;
  endtask

  // youngest pc wins, scanning mem first so that ties fall to alu1
  function automatic logic [`RV_XLEN-1:0] fwd_model(input logic [4:0] a,
                                                   input logic [`RV_XLEN-1:0] rf);
    logic [`RV_XLEN-1:0] val;
    logic [`RV_XLEN-1:0] age;
    logic                hit;
    int                  k;
    val = rf;
    age = '0;
    hit = 1'b0;
    for (k = 2; k >= 0; k--) begin
      if (byp[k].rd_ena && byp[k].rd_addr == a && a != 5'd0 && (!hit || byp[k].pc >= age)) begin
        hit = 1'b1;
        age = byp[k].pc;
        val = byp[k].data;
      end
    end
    return val;
  endfunction

  task automatic build_expected(output exp_t e);
    logic [31:0]         w;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] s1;
    logic [`RV_XLEN-1:0] s2;
    logic                out;
    w = inst;
    classify(w, e.cls, e.uop);
    if (!id_valid) begin
      e.cls = CLS_NONE;
      e.uop = UOP_NONE;
    end
    e.re1   = !(e.cls inside {CLS_NONE, CLS_LUI, CLS_AUIPC, CLS_JAL});
    e.re2   = e.cls inside {CLS_OP, CLS_OP_32, CLS_BRANCH, CLS_STORE};
    e.rd_we = !(e.cls inside {CLS_NONE, CLS_BRANCH, CLS_STORE});
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {{44{w[31]}}, w[31:12]};
    s1 = e.re1 ? fwd_model(w[19:15], rf_rdata1) : '0;
    s2 = e.re2 ? fwd_model(w[24:20], rf_rdata2) : '0;
    e.op1 = e.re1 ? s1 : (e.cls inside {CLS_AUIPC, CLS_JAL}) ? pc : '0;
    case (e.cls)
      CLS_OP, CLS_OP_32, CLS_BRANCH, CLS_STORE: e.op2 = s2;
      CLS_OP_IMM, CLS_OP_IMM_32, CLS_LOAD:      e.op2 = imm_i;
      CLS_LUI, CLS_AUIPC:                       e.op2 = imm_u;
      CLS_JAL, CLS_JALR:                        e.op2 = pc;
      default:                                  e.op2 = '0;
    endcase
    e.mem_addr = (e.cls == CLS_LOAD) ? s1 + imm_i : (e.cls == CLS_STORE) ? s1 + imm_s : '0;
    case (e.uop)
      UOP_BEQ:  out = (s1 == s2);
      UOP_BNE:  out = (s1 != s2);
      UOP_BLT:  out = ($signed(s1) < $signed(s2));
      UOP_BGE:  out = ($signed(s1) >= $signed(s2));
      UOP_BLTU: out = (s1 < s2);
      UOP_BGEU: out = (s1 >= s2);
      default:  out = 1'b0;
    endcase
    e.pht_ena  = (e.cls == CLS_BRANCH);
    e.taken    = out;
    e.redirect = (e.pht_ena && out != pht_taken) || e.cls == CLS_JALR;
    if (e.cls == CLS_JALR) e.redirect_pc = (s1 + imm_i) & ~64'd1;
    else e.redirect_pc = pht_taken ? pc + 64'd4 : pc + imm_b;
  endtask

  task automatic rand_inst(output logic [31:0] w);
    logic [31:0] r;
    logic [6:0]  opc;
    logic [2:0]  f3;
    w      = $random(seed);
    r      = $random(seed);
    opc    = kept_opc[r[15:0] % 11];
    w[6:0] = opc;
    case (opc)
      `RV_OPC_OP_32, `RV_OPC_OP_IMM_32: w[14:12] = w32_f3[r[17:16] % 3];
      `RV_OPC_LOAD:   w[14:12] = (w[14:12] == 3'd7) ? 3'd3 : w[14:12];
      `RV_OPC_STORE:  w[14] = 1'b0;
      `RV_OPC_BRANCH: w[14] = w[14] | w[13];
      `RV_OPC_JALR:   w[14:12] = 3'd0;
      default:        w[14:12] = w[14:12];
    endcase
    f3 = w[14:12];
    if (opc == `RV_OPC_OP || opc == `RV_OPC_OP_32 || (opc == `RV_OPC_OP_IMM_32 && f3 != 3'd0)) begin
      w[31:25] = {1'b0, w[30] & (f3 == 3'd5 || (f3 == 3'd0 && opc != `RV_OPC_OP_IMM_32)), 5'd0};
    end else if (opc == `RV_OPC_OP_IMM && f3[1:0] == 2'b01) begin
      w[31:26] = {1'b0, w[30] & f3[2], 4'd0};
    end
    // roughly one in ten: system, fence or m extension
    if (r[27:20] % 10 == 0) begin
      case (r[29:28])
        2'd0: w[6:0] = 7'b1110011;
        2'd1: w[6:0] = 7'b0001111;
        default: begin
          w[6:0]   = `RV_OPC_OP;
          w[31:25] = 7'd1;
        end
      endcase
    end
  endtask

  task automatic drive_random();
    logic [31:0] w;
    logic [31:0] r;
    bypass_t     nb [3];
    int          k;
    rand_inst(w);
    r = $random(seed);
    for (k = 0; k < 3; k++) begin
      nb[k].rd_ena  = r[3*k] | r[3*k+1];
      nb[k].rd_addr = r[3*k+2] ? w[19:15] : r[20+k] ? w[24:20] : 5'($random(seed));
      // small pcs make ties common
      nb[k].pc      = r[24+k] ? {60'd0, 4'($random(seed))} : {$random(seed), $random(seed)};
      nb[k].data    = {$random(seed), $random(seed)};
    end
    inst      <= w;
    id_valid  <= (r[30:28] != 3'd0);
    pht_taken <= r[31];
    pc        <= {$random(seed), $random(seed)} & ~64'h3;
    rf_rdata1 <= {$random(seed), $random(seed)};
    rf_rdata2 <= {$random(seed), $random(seed)};
    byp       <= nb;
  endtask

  task automatic check_comb();
    if (rf_re1 !== cur.re1) report_mismatch("rf_re1_o", rf_re1, cur.re1);
    if (rf_re2 !== cur.re2) report_mismatch("rf_re2_o", rf_re2, cur.re2);
    if (rf_raddr1 !== (cur.re1 ? inst[19:15] : 5'd0))
      report_mismatch("rf_raddr1_o", rf_raddr1, cur.re1 ? inst[19:15] : 5'd0);
    if (rf_raddr2 !== (cur.re2 ? inst[24:20] : 5'd0))
      report_mismatch("rf_raddr2_o", rf_raddr2, cur.re2 ? inst[24:20] : 5'd0);
    if (redirect !== cur.redirect) report_mismatch("redirect_o", redirect, cur.redirect);
    if (cur.redirect && redirect_pc !== cur.redirect_pc)
      report_mismatch("redirect_pc_o", redirect_pc, cur.redirect_pc);
    if (pht_upd.ena !== cur.pht_ena) report_mismatch("pht_upd_o.ena", pht_upd.ena, cur.pht_ena);
    if (cur.pht_ena && pht_upd.idx !== pc[5:2])
      report_mismatch("pht_upd_o.idx", pht_upd.idx, pc[5:2]);
    if (cur.pht_ena && pht_upd.taken !== cur.taken)
      report_mismatch("pht_upd_o.taken", pht_upd.taken, cur.taken);
  endtask

  task automatic check_ex();
    if (ex.valid !== prev_valid) report_mismatch("ex_o.valid", ex.valid, prev_valid);
    if (ex.cls !== prev.cls) report_mismatch("ex_o.cls", ex.cls, prev.cls);
    if (ex.uop !== prev.uop) report_mismatch("ex_o.uop", ex.uop, prev.uop);
    if (ex.rd_we !== prev.rd_we) report_mismatch("ex_o.rd_we", ex.rd_we, prev.rd_we);
    if (prev.rd_we && ex.rd_addr !== prev_inst[11:7])
      report_mismatch("ex_o.rd_addr", ex.rd_addr, prev_inst[11:7]);
    if (ex.op1 !== prev.op1) report_mismatch("ex_o.op1", ex.op1, prev.op1);
    if (ex.op2 !== prev.op2) report_mismatch("ex_o.op2", ex.op2, prev.op2);
    if (ex.mem_addr !== prev.mem_addr)
      report_mismatch("ex_o.mem_addr", ex.mem_addr, prev.mem_addr);
    if (ex.pc !== prev_pc) report_mismatch("ex_o.pc", ex.pc, prev_pc);
    if (ex.inst !== prev_inst) report_mismatch("ex_o.inst", ex.inst, prev_inst);
    if (prev.cls inside {CLS_LOAD, CLS_STORE} && ex.mem_sel !== prev_inst[14:12])
      report_mismatch("ex_o.mem_sel", ex.mem_sel, prev_inst[14:12]);
  endtask

  initial begin
    int n;
    seed      = 32'h9d56;
    errors    = 0;
    arst_n    = 1'b0;
    id_valid  = 1'b0;
    inst      = '0;
    pc        = '0;
    rf_rdata1 = '0;
    rf_rdata2 = '0;
    pht_taken = 1'b0;
    byp       = '{default: '0};
    repeat (rst_cyc - 1) @(posedge clk);
    @(negedge clk);
    if (ex !== '0) begin
      errors++;
      $display("ex_o is not cleared while reset is held");
    end
    @(posedge clk);
    arst_n <= 1'b1;
    for (n = 0; n < num_inst; n++) begin
      @(posedge clk);
      drive_random();
      @(negedge clk);
      build_expected(cur);
      check_comb();
      if (n > 0) check_ex();
      prev       = cur;
      prev_inst  = inst;
      prev_pc    = pc;
      prev_valid = id_valid;
    end
    @(posedge clk);
    @(negedge clk);
    check_ex();
    $display("checked %0d instructions, %0d errors, %0d assertion failures",
             num_inst, errors, i_dut.u_sva.fail_cnt);
    if (errors == 0 && i_dut.u_sva.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- tb_rv_decode_sva.sv
// port-level relations only, sampled on the rising edge of the decode clock
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module tb_rv_decode_sva (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input logic                    id_valid_i,
  input logic [`RV_INST_W-1:0]   inst_i,
  input logic                    pht_taken_i,
  input logic                    redirect_i,
  input rv_decode_pkg::pht_upd_t pht_upd_i,
  input rv_decode_pkg::id_ex_t   ex_i
);

  int fail_cnt = 0;

  // id/ex register held clear in reset
  a_ex_clear_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> !ex_i.valid && !ex_i.rd_we)
    else begin
      fail_cnt++;
      $error("ex_o carries a valid op while reset is held");
    end

  a_redirect_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    redirect_i |-> id_valid_i)
    else begin
      fail_cnt++;
      $error("redirect_o raised without id_valid_i");
    end

  a_update_on_branch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pht_upd_i.ena |-> id_valid_i && inst_i[6:0] == `RV_OPC_BRANCH)
    else begin
      fail_cnt++;
      $error("history update for a word that is not a branch");
    end

  // a mispredicted branch must redirect
  a_miss_redirects: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pht_upd_i.ena && (pht_upd_i.taken != pht_taken_i) |-> redirect_i)
    else begin
      fail_cnt++;
      $error("branch outcome differs from prediction but no redirect");
    end

  a_redirect_source: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    redirect_i && !pht_upd_i.ena |-> inst_i[6:0] == `RV_OPC_JALR)
    else begin
      fail_cnt++;
      $error("redirect from neither a branch nor a jalr");
    end

endmodule
